// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the profiler testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
        -f tb.f \
        --top-module tb_perf_profiler \
        --Mdir "$BUILD_DIR" \
        -o sim_tb

# The simulator exit code is not used here, the log decides
"./$BUILD_DIR/sim_tb" 2>&1 | tee "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
        echo "Simulation reported a failure, see $LOG"
        exit 1
fi

echo "Simulation finished without failures"

// File: src/perf_event_detect.sv
`timescale 1ns/10ps

module perf_event_detect import perf_pkg::*; #(
        parameter int NUM_CHANNELS = 8
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [NUM_CHANNELS-1:0] channel_idle,
        input  logic                    cfg_enable,
        input  logic                    cfg_clear,
        output logic [TS_WIDTH-1:0]     timestamp,
        output logic [NUM_CHANNELS-1:0] idle_rising,
        output logic [NUM_CHANNELS-1:0] idle_falling
);

        // Idle levels seen in the last enabled cycle
        logic [NUM_CHANNELS-1:0] idle_prev;

        // ================================================
        // Timestamp counter
        // ================================================

        // Counts enabled cycles, wraps at all ones
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        timestamp <= '0;
                end else if (cfg_clear) begin
                        timestamp <= '0;
                end else if (cfg_enable) begin
                        timestamp <= timestamp + 1'b1;
                end
        end

        // ================================================
        // Idle edge detection
        // ================================================

        // All channels start out idle
        // Clear leaves this alone so edges keep tracking the inputs
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        idle_prev <= '1;
                end else if (cfg_enable) begin
                        idle_prev <= channel_idle;
                end
        end

        // Rising is active to idle, falling is idle to active
        // Both are held low while profiling is off
        assign idle_rising  = cfg_enable ? (channel_idle & ~idle_prev) : '0;
        assign idle_falling = cfg_enable ? (~channel_idle & idle_prev) : '0;

        // Counter steps by exactly one per enabled cycle below the wrap point
        a_ts_step: assert property (@(posedge clk) disable iff (!rst_n)
                (cfg_enable && !cfg_clear && (timestamp != '1))
                |=> (timestamp == TS_WIDTH'($past(timestamp) + 1'b1)));

endmodule

// File: src/perf_fifo.sv
`timescale 1ns/10ps

module perf_fifo import perf_pkg::*; #(
        parameter int FIFO_DEPTH = 256
) (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   cfg_clear,
        input  logic                   wr_en,
        input  perf_entry_u            wr_entry,
        input  logic                   rd_pop,
        output perf_entry_u            rd_entry,
        output logic                   empty,
        output logic                   full,
        output logic [COUNT_WIDTH-1:0] count
);

        // Pointer width, depth is a power of two
        localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

        // Occupancy value that means full
        localparam logic [ADDR_WIDTH:0] DEPTH_COUNT = (ADDR_WIDTH + 1)'(FIFO_DEPTH);

        // Entry storage
        perf_entry_u           mem [FIFO_DEPTH];

        // Circular pointers, wrap by overflow
        logic [ADDR_WIDTH-1:0] wr_ptr;
        logic [ADDR_WIDTH-1:0] rd_ptr;

        // One bit wider than the pointers to hold FIFO_DEPTH
        logic [ADDR_WIDTH:0]   occ;

        // Accepted operations
        logic                  do_write;
        logic                  do_read;

        // ================================================
        // Status and accept
        // ================================================

        assign full  = (occ == DEPTH_COUNT);
        assign empty = (occ == '0);

        // Drop on full, no back-pressure
        assign do_write = wr_en && !full;
        // Pop on empty is ignored
        assign do_read  = rd_pop && !empty;

        assign count    = COUNT_WIDTH'(occ);

        // Head of queue, seen by the read latch
        assign rd_entry = mem[rd_ptr];

        // ================================================
        // Storage and pointers
        // ================================================

        always_ff @(posedge clk) begin
                if (do_write) begin
                        mem[wr_ptr] <= wr_entry;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        occ    <= '0;
                end else if (cfg_clear) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        occ    <= '0;
                end else begin
                        if (do_write) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (do_read) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        // Write and pop together leave occupancy alone
                        case ({do_write, do_read})
                                2'b10:   occ <= occ + 1'b1;
                                2'b01:   occ <= occ - 1'b1;
                                default: occ <= occ;
                        endcase
                end
        end

        a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
                occ <= DEPTH_COUNT);

endmodule

// File: src/perf_pkg.sv
package perf_pkg;

        // ================================================
        // Widths
        // ================================================

        // Free-running counter, start times and elapsed value
        localparam int TS_WIDTH = 32;

        // Channel tag inside an entry, fixed so up to 8 channels fit
        localparam int CH_ID_WIDTH = 3;

        // One FIFO entry is event type, channel ID and value
        localparam int ENTRY_WIDTH = 1 + CH_ID_WIDTH + TS_WIDTH;

        // Bits above the low read word
        localparam int HIGH_WIDTH = ENTRY_WIDTH - TS_WIDTH;

        // External occupancy output, wide enough for a 32768-deep FIFO
        localparam int COUNT_WIDTH = 16;

        // ================================================
        // Encodings
        // ================================================

        // cfg_mode values
        localparam logic MODE_TIMESTAMP = 1'b0;
        localparam logic MODE_ELAPSED   = 1'b1;

        // Event type in bit 35 of an entry
        // Start is idle to active, end is active to idle
        localparam logic EVENT_START = 1'b0;
        localparam logic EVENT_END   = 1'b1;

        // ================================================
        // FIFO entry
        // ================================================

        // Written as a record, read back as two bus words
        typedef union packed {
                struct packed {
                        logic                   event_type;
                        logic [CH_ID_WIDTH-1:0] ch_id;
                        logic [TS_WIDTH-1:0]    value;
                } rec;
                struct packed {
                        logic [HIGH_WIDTH-1:0]  high;
                        logic [TS_WIDTH-1:0]    low;
                } words;
        } perf_entry_u;

endpackage

// File: src/perf_profiler.sv
`timescale 1ns/10ps

module perf_profiler import perf_pkg::*; #(
        parameter int NUM_CHANNELS = 8,
        parameter int FIFO_DEPTH   = 256
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [NUM_CHANNELS-1:0] channel_idle,
        input  logic                    cfg_enable,
        input  logic                    cfg_mode,
        input  logic                    cfg_clear,
        input  logic                    perf_fifo_rd,
        output logic [TS_WIDTH-1:0]     perf_fifo_data_low,
        output logic [TS_WIDTH-1:0]     perf_fifo_data_high,
        output logic                    perf_fifo_empty,
        output logic                    perf_fifo_full,
        output logic [COUNT_WIDTH-1:0]  perf_fifo_count
);

        // Detector to record builder
        logic [TS_WIDTH-1:0]     timestamp;
        logic [NUM_CHANNELS-1:0] idle_rising;
        logic [NUM_CHANNELS-1:0] idle_falling;

        // Record builder to FIFO
        logic                    wr_en;
        perf_entry_u             wr_entry;

        // FIFO head to read latch
        perf_entry_u             rd_entry;

        // ================================================
        // Event path
        // ================================================

        perf_event_detect #(
                .NUM_CHANNELS (NUM_CHANNELS)
        ) u_event_detect (
                .clk          (clk),
                .rst_n        (rst_n),
                .channel_idle (channel_idle),
                .cfg_enable   (cfg_enable),
                .cfg_clear    (cfg_clear),
                .timestamp    (timestamp),
                .idle_rising  (idle_rising),
                .idle_falling (idle_falling)
        );

        perf_record_build #(
                .NUM_CHANNELS (NUM_CHANNELS)
        ) u_record_build (
                .clk          (clk),
                .rst_n        (rst_n),
                .cfg_mode     (cfg_mode),
                .cfg_clear    (cfg_clear),
                .timestamp    (timestamp),
                .idle_rising  (idle_rising),
                .idle_falling (idle_falling),
                .wr_en        (wr_en),
                .wr_entry     (wr_entry)
        );

        // ================================================
        // Buffer and read side
        // ================================================

        perf_fifo #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
                .clk       (clk),
                .rst_n     (rst_n),
                .cfg_clear (cfg_clear),
                .wr_en     (wr_en),
                .wr_entry  (wr_entry),
                .rd_pop    (perf_fifo_rd),
                .rd_entry  (rd_entry),
                .empty     (perf_fifo_empty),
                .full      (perf_fifo_full),
                .count     (perf_fifo_count)
        );

        perf_read_port u_read_port (
                .clk       (clk),
                .rst_n     (rst_n),
                .cfg_clear (cfg_clear),
                .rd_pop    (perf_fifo_rd),
                .empty     (perf_fifo_empty),
                .rd_entry  (rd_entry),
                .data_low  (perf_fifo_data_low),
                .data_high (perf_fifo_data_high)
        );

endmodule

// File: src/perf_read_port.sv
`timescale 1ns/10ps

module perf_read_port import perf_pkg::*; (
        input  logic                clk,
        input  logic                rst_n,
        input  logic                cfg_clear,
        input  logic                rd_pop,
        input  logic                empty,
        input  perf_entry_u         rd_entry,
        output logic [TS_WIDTH-1:0] data_low,
        output logic [TS_WIDTH-1:0] data_high
);

        // Whole entry held across the low and high word reads
        perf_entry_u latched;

        // ================================================
        // Pop latch
        // ================================================

        // Only an accepted pop loads, a strobe on empty keeps old words
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        latched <= '0;
                end else if (cfg_clear) begin
                        latched <= '0;
                end else if (rd_pop && !empty) begin
                        latched <= rd_entry;
                end
        end

        // Low word is the timestamp or elapsed value
        assign data_low  = latched.words.low;
        // High word is event type over channel ID, zero-extended
        assign data_high = {{(TS_WIDTH - HIGH_WIDTH){1'b0}}, latched.words.high};

endmodule

// File: src/perf_record_build.sv
`timescale 1ns/10ps

module perf_record_build import perf_pkg::*; #(
        parameter int NUM_CHANNELS = 8
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    cfg_mode,
        input  logic                    cfg_clear,
        input  logic [TS_WIDTH-1:0]     timestamp,
        input  logic [NUM_CHANNELS-1:0] idle_rising,
        input  logic [NUM_CHANNELS-1:0] idle_falling,
        output logic                    wr_en,
        output perf_entry_u             wr_entry
);

        // Counter value at the start of each channel's active period
        logic [TS_WIDTH-1:0]     start_time [NUM_CHANNELS];

        // Set while a start was seen in elapsed mode and no end yet
        logic [NUM_CHANNELS-1:0] active;

        // Channels with an event worth recording this cycle
        logic [NUM_CHANNELS-1:0] qual;

        // Winning channel and whether any channel qualified
        logic [CH_ID_WIDTH-1:0]  sel_ch;
        logic                    sel_valid;

        // End counter minus start counter of the winner
        logic [TS_WIDTH-1:0]     elapsed;

        // ================================================
        // Per-channel start tracking
        // ================================================

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        active <= '0;
                        for (int c = 0; c < NUM_CHANNELS; c++) begin
                                start_time[c] <= '0;
                        end
                end else if (cfg_clear) begin
                        active <= '0;
                        for (int c = 0; c < NUM_CHANNELS; c++) begin
                                start_time[c] <= '0;
                        end
                end else begin
                        for (int c = 0; c < NUM_CHANNELS; c++) begin
                                // Only elapsed mode opens an active period
                                if (idle_falling[c] && (cfg_mode == MODE_ELAPSED)) begin
                                        start_time[c] <= timestamp;
                                        active[c]     <= 1'b1;
                                end else if (idle_rising[c]) begin
                                        // Any return to idle closes it, whatever the mode
                                        active[c] <= 1'b0;
                                end
                        end
                end
        end

        // ================================================
        // Event qualification and priority
        // ================================================

        // Timestamp mode takes both edges
        // Elapsed mode takes an end only with a start on record
        always_comb begin
                if (cfg_mode == MODE_TIMESTAMP) begin
                        qual = idle_rising | idle_falling;
                end else begin
                        qual = idle_rising & active;
                end
        end

        // Walk down so the lowest qualifying channel is left standing
        // Other events in the same cycle are dropped
        always_comb begin
                sel_valid = 1'b0;
                sel_ch    = '0;
                for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
                        if (qual[i]) begin
                                sel_valid = 1'b1;
                                sel_ch    = CH_ID_WIDTH'(i);
                        end
                end
        end

        // ================================================
        // Entry assembly
        // ================================================

        // Modular difference, so a wrap in between still gives the length
        assign elapsed = timestamp - start_time[sel_ch];

        always_comb begin
                wr_entry = '0;
                if (cfg_mode == MODE_TIMESTAMP) begin
                        wr_entry.rec.event_type = idle_rising[sel_ch] ? EVENT_END : EVENT_START;
                        wr_entry.rec.value      = timestamp;
                end else begin
                        // Elapsed entries are always end events
                        wr_entry.rec.event_type = EVENT_END;
                        wr_entry.rec.value      = elapsed;
                end
                wr_entry.rec.ch_id = sel_ch;
        end

        // FIFO decides on its own whether there is room
        assign wr_en = sel_valid;

        // Elapsed write needs an open period and closes it on the next edge
        a_elapsed_active: assert property (@(posedge clk) disable iff (!rst_n)
                (wr_en && (cfg_mode == MODE_ELAPSED) && !cfg_clear)
                |=> ($past(active[sel_ch]) && !active[$past(sel_ch)]));

endmodule

// File: tb.f
+incdir+include
src/perf_pkg.sv
src/perf_event_detect.sv
src/perf_record_build.sv
src/perf_fifo.sv
src/perf_read_port.sv
src/perf_profiler.sv
testbench/tb_perf_profiler.sv

// File: include/perf_tb_tasks.svh
`ifndef PERF_TB_TASKS_SVH
`define PERF_TB_TASKS_SVH

// ================================================
// Helpers
// ================================================

// Hold length of 2 to 20 cycles
function automatic int random_hold();
        return 2 + int'($urandom % 19);
endfunction

// All channels idle, then a one-cycle clear so FIFO and counter start fresh
task automatic restart_profiler(input logic mode);
        @(negedge clk);
        channel_idle = '1;
        cfg_enable   = 1'b1;
        cfg_mode     = mode;
        @(negedge clk);
        cfg_clear = 1'b1;
        @(negedge clk);
        cfg_clear = 1'b0;
        check_value("perf_fifo_empty", 32'(perf_fifo_empty), 32'd1);
endtask

// Bounded wait on the occupancy output
task automatic wait_for_count(input int n);
        int waited;
        waited = 0;
        while (perf_fifo_count != COUNT_WIDTH'(n)) begin
                if (waited == 40) begin
                        stop_with_failure($sformatf("FIFO count never reached %0d", n));
                end
                @(negedge clk);
                waited++;
        end
endtask

// One-cycle pop strobe, words sampled on the next falling edge
task automatic read_entry(output logic [31:0] low, output logic [31:0] high);
        perf_fifo_rd = 1'b1;
        @(negedge clk);
        perf_fifo_rd = 1'b0;
        low  = perf_fifo_data_low;
        high = perf_fifo_data_high;
endtask

task automatic check_read(input logic [31:0] exp_high, input logic [31:0] exp_low);
        logic [31:0] low;
        logic [31:0] high;
        read_entry(low, high);
        check_value("perf_fifo_data_high", high, exp_high);
        check_value("perf_fifo_data_low", low, exp_low);
endtask

// High word is event type in bit 3 over the channel number
task automatic expect_entry(input int ch, input logic ev, input logic [31:0] value);
        check_read({28'd0, ev, 3'(ch)}, value);
endtask

// ================================================
// Directed tests
// ================================================

task automatic check_reset_state();
        check_value("perf_fifo_empty", 32'(perf_fifo_empty), 32'd1);
        check_value("perf_fifo_full", 32'(perf_fifo_full), 32'd0);
        check_value("perf_fifo_count", 32'(perf_fifo_count), 32'd0);
        check_value("perf_fifo_data_low", perf_fifo_data_low, 32'd0);
        check_value("perf_fifo_data_high", perf_fifo_data_high, 32'd0);
endtask

task automatic record_timestamps();
        int          hold;
        logic [31:0] start_ts;
        hold = random_hold();
        restart_profiler(MODE_TIMESTAMP);
        channel_idle[3] = 1'b0;
        start_ts = model_ts;
        // Entry lands one cycle after the change
        @(negedge clk);
        check_value("perf_fifo_empty", 32'(perf_fifo_empty), 32'd0);
        repeat (hold - 1) @(negedge clk);
        channel_idle[3] = 1'b1;
        wait_for_count(2);
        expect_entry(3, EVENT_START, start_ts);
        expect_entry(3, EVENT_END, start_ts + 32'(hold));
endtask

task automatic measure_elapsed();
        int          hold;
        logic [31:0] start_ts;
        hold = random_hold();
        restart_profiler(MODE_TIMESTAMP);
        // Channel 1 goes active in timestamp mode and logs only a start entry
        channel_idle[1] = 1'b0;
        start_ts = model_ts;
        @(negedge clk);
        cfg_mode = MODE_ELAPSED;
        channel_idle[5] = 1'b0;
        repeat (hold) @(negedge clk);
        channel_idle[5] = 1'b1;
        wait_for_count(2);
        // End with no start on record
        channel_idle[1] = 1'b1;
        repeat (3) @(negedge clk);
        check_value("perf_fifo_count", 32'(perf_fifo_count), 32'd2);
        expect_entry(1, EVENT_START, start_ts);
        expect_entry(5, EVENT_END, 32'(hold));
endtask

task automatic pick_lowest_channel();
        logic [31:0] start_ts;
        restart_profiler(MODE_TIMESTAMP);
        channel_idle[2] = 1'b0;
        channel_idle[6] = 1'b0;
        start_ts = model_ts;
        wait_for_count(1);
        repeat (3) @(negedge clk);
        check_value("perf_fifo_count", 32'(perf_fifo_count), 32'd1);
        expect_entry(2, EVENT_START, start_ts);
endtask

task automatic fill_and_drain();
        logic [31:0] exp_low [$];
        logic [31:0] exp_high [$];
        logic [31:0] last_low;
        logic [31:0] last_high;
        logic [2:0]  ch;
        logic        ev;
        restart_profiler(MODE_TIMESTAMP);
        // One toggle per cycle on channels 0 to 7 in turn
        for (int k = 0; k < 20; k++) begin
                ch = 3'(k % NUM_CH);
                ev = channel_idle[ch] ? EVENT_START : EVENT_END;
                exp_high.push_back({28'd0, ev, ch});
                exp_low.push_back(model_ts);
                channel_idle[ch] = ~channel_idle[ch];
                @(negedge clk);
        end
        wait_for_count(DEPTH);
        repeat (2) @(negedge clk);
        check_value("perf_fifo_count", 32'(perf_fifo_count), 32'(DEPTH));
        check_value("perf_fifo_full", 32'(perf_fifo_full), 32'd1);
        // Last four were dropped, the rest come out in order
        for (int k = 0; k < DEPTH; k++) begin
                last_high = exp_high.pop_front();
                last_low  = exp_low.pop_front();
                check_read(last_high, last_low);
        end
        check_value("perf_fifo_empty", 32'(perf_fifo_empty), 32'd1);
        check_value("perf_fifo_full", 32'(perf_fifo_full), 32'd0);
        // Strobe on empty keeps the sixteenth entry on both words
        check_read(last_high, last_low);
endtask

task automatic disable_then_clear();
        int          hold;
        logic [31:0] held_ts;
        hold = random_hold();
        restart_profiler(MODE_TIMESTAMP);
        repeat (4) @(negedge clk);
        cfg_enable = 1'b0;
        held_ts    = model_ts;
        channel_idle[4] = 1'b0;
        repeat (hold) @(negedge clk);
        channel_idle[4] = 1'b1;
        repeat (3) @(negedge clk);
        check_value("perf_fifo_count", 32'(perf_fifo_count), 32'd0);
        check_value("perf_fifo_empty", 32'(perf_fifo_empty), 32'd1);
        // Counter resumes from where it stopped
        cfg_enable = 1'b1;
        channel_idle[4] = 1'b0;
        wait_for_count(1);
        channel_idle[4] = 1'b1;
        wait_for_count(2);
        expect_entry(4, EVENT_START, held_ts);
        cfg_clear = 1'b1;
        @(negedge clk);
        cfg_clear = 1'b0;
        check_value("perf_fifo_empty", 32'(perf_fifo_empty), 32'd1);
        check_value("perf_fifo_count", 32'(perf_fifo_count), 32'd0);
        check_value("perf_fifo_data_low", perf_fifo_data_low, 32'd0);
        check_value("perf_fifo_data_high", perf_fifo_data_high, 32'd0);
        // Zero right after clear, two enabled cycles later it reads 2
        repeat (2) @(negedge clk);
        channel_idle[6] = 1'b0;
        wait_for_count(1);
        expect_entry(6, EVENT_START, 32'd2);
endtask

`endif

// File: testbench/tb_perf_profiler.sv
`timescale 1ns/10ps

module tb_perf_profiler import perf_pkg::*; ();

        // DUT sizing for this run
        localparam int NUM_CH     = 8;
        localparam int DEPTH      = 16;
        // Directed tests need well under 1200 cycles
        localparam int MAX_CYCLES = 3000;

        logic                   clk;
        logic                   rst_n;
        logic [NUM_CH-1:0]      channel_idle;
        logic                   cfg_enable;
        logic                   cfg_mode;
        logic                   cfg_clear;
        logic                   perf_fifo_rd;
        logic [TS_WIDTH-1:0]    perf_fifo_data_low;
        logic [TS_WIDTH-1:0]    perf_fifo_data_high;
        logic                   perf_fifo_empty;
        logic                   perf_fifo_full;
        logic [COUNT_WIDTH-1:0] perf_fifo_count;

        // Expected counter, enabled non-clearing cycles since the last clear
        logic [TS_WIDTH-1:0]    model_ts;

        int                     cycle_count = 0;
        int                     error_count = 0;

        perf_profiler #(
                .NUM_CHANNELS (NUM_CH),
                .FIFO_DEPTH   (DEPTH)
        ) DUT (
                .clk                 (clk),
                .rst_n               (rst_n),
                .channel_idle        (channel_idle),
                .cfg_enable          (cfg_enable),
                .cfg_mode            (cfg_mode),
                .cfg_clear           (cfg_clear),
                .perf_fifo_rd        (perf_fifo_rd),
                .perf_fifo_data_low  (perf_fifo_data_low),
                .perf_fifo_data_high (perf_fifo_data_high),
                .perf_fifo_empty     (perf_fifo_empty),
                .perf_fifo_full      (perf_fifo_full),
                .perf_fifo_count     (perf_fifo_count)
        );

        // ================================================
        // Clock, counter model and watchdog
        // ================================================

        // 8 ns period
        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Counter starts at zero after reset or clear, steps while enabled
        always @(posedge clk) begin
                if (!rst_n || cfg_clear) begin
                        model_ts <= '0;
                end else if (cfg_enable) begin
                        model_ts <= model_ts + 32'd1;
                end
        end

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= MAX_CYCLES) begin
                        stop_with_failure($sformatf("Timeout, run still busy after %0d cycles",
                                MAX_CYCLES));
                end
        end

        // ================================================
        // Failure reporting
        // ================================================

        task automatic stop_with_failure(input string reason);
                error_count++;
                $display("%s", reason);
                $display("TESTBENCH FAILED");
                $fatal(1, "Run stopped at first error");
        endtask

        // Compare one observed value with its expected value
        task automatic check_value(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
                if (actual !== expected) begin
                        stop_with_failure($sformatf("FAILED time %0t: %s = 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
                end
        endtask

        `include "perf_tb_tasks.svh"

        // ================================================
        // Test sequence
        // ================================================

        initial begin
                rst_n        = 1'b0;
                channel_idle = '1;
                cfg_enable   = 1'b0;
                cfg_mode     = MODE_TIMESTAMP;
                cfg_clear    = 1'b0;
                perf_fifo_rd = 1'b0;
                void'($urandom(32'h1fd6));

                // Three reset cycles, released on a falling edge
                repeat (3) @(negedge clk);
                rst_n = 1'b1;

                check_reset_state();
                record_timestamps();
                measure_elapsed();
                pick_lowest_channel();
                fill_and_drain();
                disable_then_clear();

                @(negedge clk);
                if (error_count == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule
